// ==== dcache_pkg.sv ====
package dcache_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // line geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int LINE_BYTES = 64;                    // bytes per line.
    localparam int WORD_BYTES = 4;                     // bytes per bus word.
    localparam int LINE_WORDS = LINE_BYTES / WORD_BYTES;
    localparam int SETS       = 16;                    // direct mapped, one way.
    localparam int OFFSET_W   = 6;                     // byte offset inside a line.
    localparam int INDEX_W    = 4;                     // set index above the offset.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // vector types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // byte address from the core.
    typedef logic [31:0] addr_t;

    // store data and uncached bus data.
    typedef logic [WORD_BYTES*8-1:0] word_t;

    // one full cache line, also the refill beat.
    typedef logic [LINE_BYTES*8-1:0] line_t;

    // per-byte write enable across a line.
    typedef logic [LINE_BYTES-1:0] line_be_t;

    // byte strobe of one word.
    typedef logic [WORD_BYTES-1:0] wstrb_t;

    // selects one of the SETS lines.
    typedef logic [INDEX_W-1:0] index_t;

endpackage

// ==== dcache_ctrl_pkg.sv ====
package dcache_ctrl_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write type codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a store type is a byte mask anchored at byte 0 of the word.
    typedef logic [3:0] wrt_type_t;

    localparam wrt_type_t WRT_BYTE = 4'b0001;
    localparam wrt_type_t WRT_HALF = 4'b0011;
    localparam wrt_type_t WRT_WORD = 4'b1111;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // store sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        IDLE,           // nothing buffered.
        WRITE,          // store to a resident line.
        WAIT_REFILL,    // line missing, waiting on the bus.
        MERGE,          // refill written, store goes on top.
        UNCACHED        // store leaves as one word.
    } store_state_t;

endpackage

// ==== dcache_req_buf.sv ====
`timescale 1ns/1ps

module dcache_req_buf
    import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   req_valid,
    input  logic   busy,
    input  addr_t  req_addr,
    input  word_t  req_wdata,
    input  wstrb_t req_type,
    input  logic   req_uncache,
    input  logic   req_cacop,
    input  logic   req_refill,
    input  logic   rbuf_clear,
    output logic   rbuf_valid,
    output addr_t  rbuf_addr,
    output word_t  rbuf_wdata,
    output wstrb_t rbuf_type,
    output logic   rbuf_uncache,
    output logic   rbuf_cacop,
    output logic   rbuf_refill
);

    logic accept;

    // a request is taken only while nothing is in flight.
    assign accept = req_valid & ~busy;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // occupancy
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rbuf_valid <= 1'b0;
        end else if (rbuf_clear) begin
            rbuf_valid <= 1'b0;                 // request retired.
        end else if (accept) begin
            rbuf_valid <= 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // payload, held steady across a refill wait
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (accept) begin
            rbuf_addr    <= req_addr;
            rbuf_wdata   <= req_wdata;
            rbuf_type    <= req_type;
            rbuf_uncache <= req_uncache;
            rbuf_cacop   <= req_cacop;
            rbuf_refill  <= req_refill;
        end
    end

endmodule

// ==== mem_wrt_ctrl_d.sv ====
`timescale 1ns/1ps

module mem_wrt_ctrl_d
    import dcache_pkg::*;
    import dcache_ctrl_pkg::*;
(
    input  word_t     w_data_CPU,
    input  line_t     w_data_AXI,
    input  addr_t     addr_rbuf,
    input  wrt_type_t wrt_type,
    input  logic      wrt_data_sel,
    input  logic      cacop_en_rbuf,
    input  logic      uncache_rbuf,
    output line_t     mem_din,
    output line_be_t  mem_we_normal,
    output wstrb_t    AXI_we
);

    wstrb_t     we_word;                        // enables inside one word.
    logic [3:0] word_slot;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write data
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // store data is copied into every lane so that the enables alone
    // decide where it lands.
    always_comb begin
        if (!wrt_data_sel) begin
            mem_din = w_data_AXI;               // refill line as is.
        end else begin
            case (wrt_type)
                WRT_BYTE: mem_din = {LINE_BYTES{w_data_CPU[7:0]}};
                WRT_HALF: mem_din = {(LINE_BYTES / 2){w_data_CPU[15:0]}};
                WRT_WORD: mem_din = {LINE_WORDS{w_data_CPU}};
                default:  mem_din = '0;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // byte enables
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // index operations carry a raw mask, so no sub-word alignment.
    always_comb begin
        if (cacop_en_rbuf) begin
            we_word = wrt_type;
        end else begin
            case (addr_rbuf[1:0])
                2'd0:    we_word = wrt_type;
                2'd1:    we_word = {wrt_type[2:0], 1'b0};
                2'd2:    we_word = {wrt_type[1:0], 2'b0};
                default: we_word = {wrt_type[0], 3'b0};
            endcase
        end
    end

    assign word_slot = addr_rbuf[OFFSET_W-1:2];

    // the word enables land in the addressed slot, all others stay off.
    always_comb begin
        for (int w = 0; w < LINE_WORDS; w++) begin
            if (word_slot == w[3:0]) begin
                mem_we_normal[WORD_BYTES*w +: WORD_BYTES] = we_word;
            end else begin
                mem_we_normal[WORD_BYTES*w +: WORD_BYTES] = '0;
            end
        end
    end

    // a cached path has no use for the strobe, hence all ones.
    assign AXI_we = uncache_rbuf ? we_word : '1;

endmodule

// ==== dcache_data_mem.sv ====
`timescale 1ns/1ps

module dcache_data_mem
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     we,
    input  logic     line_we_all,
    input  index_t   index,
    input  line_be_t be,
    input  line_t    din,
    input  index_t   rd_index,
    output line_t    rd_data
);

    line_t    mem [SETS];
    index_t   clr_idx;                          // walks the sets during reset.
    line_be_t wr_be;

    // a refill replaces the whole line.
    assign wr_be = line_we_all ? '1 : be;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one set is zeroed per reset cycle; the pointer wraps, so SETS
    // reset cycles cover every line from any start value.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem[clr_idx] <= '0;
            clr_idx      <= clr_idx + 1'b1;
        end else if (we) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (wr_be[b]) begin
                    mem[index][8*b +: 8] <= din[8*b +: 8];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // debug read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_index];               // one cycle read latency.
    end

endmodule

// ==== dcache_store_fsm.sv ====
`timescale 1ns/1ps

module dcache_store_fsm
    import dcache_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic rbuf_valid,
    input  logic rbuf_uncache,
    input  logic rbuf_refill,
    input  logic refill_valid,
    output logic busy,
    output logic wrt_data_sel,
    output logic mem_we,
    output logic line_we_all,
    output logic uc_wvalid,
    output logic done,
    output logic rbuf_clear
);

    store_state_t state;
    store_state_t cur_state;
    store_state_t next_state;
    logic         fin;                          // a store write landed last cycle.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a new request acts in the very cycle it appears in the buffer,
    // so IDLE hands over to the decoded state without a dead cycle.
    // while fin is high the buffer still holds the retiring request.
    always_comb begin
        cur_state = state;
        if (state == IDLE && rbuf_valid && !fin) begin
            if (rbuf_uncache) begin
                cur_state = UNCACHED;           // refill flag has no meaning here.
            end else if (rbuf_refill) begin
                cur_state = WAIT_REFILL;
            end else begin
                cur_state = WRITE;              // hit or index cache op.
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // outputs and next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        next_state   = cur_state;
        wrt_data_sel = 1'b1;
        mem_we       = 1'b0;
        line_we_all  = 1'b0;
        uc_wvalid    = 1'b0;
        case (cur_state)
            WRITE: begin
                mem_we     = 1'b1;
                next_state = IDLE;
            end
            WAIT_REFILL: begin
                if (refill_valid) begin
                    wrt_data_sel = 1'b0;        // bus line goes in first.
                    mem_we       = 1'b1;
                    line_we_all  = 1'b1;
                    next_state   = MERGE;
                end
            end
            MERGE: begin
                mem_we     = 1'b1;              // store on top of the refill.
                next_state = IDLE;
            end
            UNCACHED: begin
                uc_wvalid  = 1'b1;
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            fin   <= 1'b0;
        end else begin
            state <= next_state;
            fin   <= mem_we & wrt_data_sel;
        end
    end

    // an uncached store completes with its bus beat.
    assign done       = fin | uc_wvalid;
    assign rbuf_clear = done;
    assign busy       = rbuf_valid | (state != IDLE);

endmodule

// ==== dcache_wr_path.sv ====
`timescale 1ns/1ps

module dcache_wr_path
    import dcache_pkg::*;
    import dcache_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_valid,
    input  addr_t     req_addr,
    input  word_t     req_wdata,
    input  wrt_type_t req_type,
    input  logic      req_uncache,
    input  logic      req_cacop,
    input  logic      req_refill,
    input  logic      refill_valid,
    input  line_t     refill_data,
    input  index_t    rd_index,
    output logic      busy,
    output logic      done,
    output logic      uc_wvalid,
    output addr_t     uc_addr,
    output word_t     uc_wdata,
    output wstrb_t    uc_wstrb,
    output line_t     rd_data
);

    logic      rbuf_valid;
    addr_t     rbuf_addr;
    word_t     rbuf_wdata;
    wrt_type_t rbuf_type;
    logic      rbuf_uncache;
    logic      rbuf_cacop;
    logic      rbuf_refill;
    logic      rbuf_clear;

    logic      wrt_data_sel;
    logic      mem_we;
    logic      line_we_all;
    line_t     mem_din;
    line_be_t  mem_we_normal;
    wstrb_t    AXI_we;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request capture and sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    dcache_req_buf dcache_req_buf_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .busy         (busy),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .req_type     (req_type),
        .req_uncache  (req_uncache),
        .req_cacop    (req_cacop),
        .req_refill   (req_refill),
        .rbuf_clear   (rbuf_clear),
        .rbuf_valid   (rbuf_valid),
        .rbuf_addr    (rbuf_addr),
        .rbuf_wdata   (rbuf_wdata),
        .rbuf_type    (rbuf_type),
        .rbuf_uncache (rbuf_uncache),
        .rbuf_cacop   (rbuf_cacop),
        .rbuf_refill  (rbuf_refill)
    );

    dcache_store_fsm dcache_store_fsm_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .rbuf_valid   (rbuf_valid),
        .rbuf_uncache (rbuf_uncache),
        .rbuf_refill  (rbuf_refill),
        .refill_valid (refill_valid),
        .busy         (busy),
        .wrt_data_sel (wrt_data_sel),
        .mem_we       (mem_we),
        .line_we_all  (line_we_all),
        .uc_wvalid    (uc_wvalid),
        .done         (done),
        .rbuf_clear   (rbuf_clear)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    mem_wrt_ctrl_d mem_wrt_ctrl_d_inst (
        .w_data_CPU    (rbuf_wdata),
        .w_data_AXI    (refill_data),
        .addr_rbuf     (rbuf_addr),
        .wrt_type      (rbuf_type),
        .wrt_data_sel  (wrt_data_sel),
        .cacop_en_rbuf (rbuf_cacop),
        .uncache_rbuf  (rbuf_uncache),
        .mem_din       (mem_din),
        .mem_we_normal (mem_we_normal),
        .AXI_we        (AXI_we)
    );

    dcache_data_mem dcache_data_mem_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .we          (mem_we),
        .line_we_all (line_we_all),
        .index       (rbuf_addr[OFFSET_W +: INDEX_W]),  // address bits 9 to 6.
        .be          (mem_we_normal),
        .din         (mem_din),
        .rd_index    (rd_index),
        .rd_data     (rd_data)
    );

    // uncached beat is word aligned; the replicated data fills every lane.
    assign uc_addr  = {rbuf_addr[31:2], 2'b00};
    assign uc_wdata = mem_din[31:0];
    assign uc_wstrb = AXI_we;

endmodule

// ==== dcache_wr_path_sva.sv ====
`timescale 1ns/1ps

module dcache_wr_path_sva (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic done,
    input logic uc_wvalid,
    input logic mem_we
);

    int fail_cnt = 0;                           // sampled by the testbench at the end.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // completion and bus exclusivity
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            fail_cnt++;
            $error("done stayed high for two cycles");
        end

    // an uncached beat never touches the data memory.
    a_uc_no_mem: assert property (@(posedge clk) disable iff (!rst_n) !(uc_wvalid && mem_we))
        else begin
            fail_cnt++;
            $error("uc_wvalid and mem_we high together");
        end

    a_idle_after_done: assert property (@(posedge clk) disable iff (!rst_n) done |=> !busy)
        else begin
            fail_cnt++;
            $error("busy still high after done");
        end

endmodule

bind dcache_store_fsm dcache_wr_path_sva dcache_wr_path_sva_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .busy      (busy),
    .done      (done),
    .uc_wvalid (uc_wvalid),
    .mem_we    (mem_we)
);

// ==== tb_dcache_wr_path.sv ====
`timescale 1ns/1ps

module tb_dcache_wr_path
    import dcache_pkg::*;
    import dcache_ctrl_pkg::*;
();

    logic      clk;
    logic      rst_n;
    logic      req_valid;
    addr_t     req_addr;
    word_t     req_wdata;
    wrt_type_t req_type;
    logic      req_uncache;
    logic      req_cacop;
    logic      req_refill;
    logic      refill_valid;
    line_t     refill_data;
    index_t    rd_index;
    logic      busy;
    logic      done;
    logic      uc_wvalid;
    addr_t     uc_addr;
    word_t     uc_wdata;
    wstrb_t    uc_wstrb;
    line_t     rd_data;

    line_t       model_mem [SETS];              // expected contents of every set.
    logic [31:0] lfsr = 32'hcffc;
    wrt_type_t   type_list [3] = '{WRT_BYTE, WRT_HALF, WRT_WORD};

    dcache_wr_path dcache_wr_path_inst (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic word_t lane_copy(input word_t data, input wrt_type_t wtype);
        case (wtype)
            WRT_BYTE: return {4{data[7:0]}};
            WRT_HALF: return {2{data[15:0]}};
            WRT_WORD: return data;
            default:  return '0;
        endcase
    endfunction

    // replicate, shift unless cache op, then place the mask in the addressed word.
    function automatic line_t apply_store(input line_t old, input addr_t addr, input word_t data,
                                          input wrt_type_t wtype, input logic cacop);
        line_t  res;
        word_t  rep;
        wstrb_t mask;
        int     slot;
        res  = old;
        rep  = lane_copy(data, wtype);
        mask = cacop ? wtype : wstrb_t'(wtype << addr[1:0]);
        slot = int'(addr[5:2]);
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (b / 4 == slot && mask[b % 4]) begin
                res[8*b +: 8] = rep[8*(b % 4) +: 8];
            end
        end
        return res;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_val(input line_t got, input line_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    task automatic check_quiet(input string what);
        check_val(line_t'(busy), '0, {what, ": busy"});
        check_val(line_t'(done), '0, {what, ": done"});
        check_val(line_t'(uc_wvalid), '0, {what, ": uc_wvalid"});
    endtask

    // kind 0 waits for done, 1 for uc_wvalid, 2 for busy low.
    task automatic wait_event(input int kind, input string what);
        int n;
        n = 0;
        while (!((kind == 0 && done) || (kind == 1 && uc_wvalid) || (kind == 2 && !busy))) begin
            if (n == 100) begin
                $display("timeout after 100 cycles waiting for %s", what);
                $display("TEST FAILED");
                $fatal(1, "stopping on timeout");
            end
            step();
            n++;
        end
    endtask

    task automatic read_line(input index_t idx, output line_t val);
        rd_index = idx;
        step();
        val = rd_data;
    endtask

    task automatic send_req(input addr_t addr, input word_t data, input wrt_type_t wtype,
                            input logic uc, input logic cacop, input logic refill);
        wait_event(2, "busy to drop before a request");
        req_valid   = 1'b1;
        req_addr    = addr;
        req_wdata   = data;
        req_type    = wtype;
        req_uncache = uc;
        req_cacop   = cacop;
        req_refill  = refill;
        step();
        req_valid = 1'b0;
        check_val(line_t'(busy), line_t'(1'b1), "busy after accept");
    endtask

    task automatic cached_store(input addr_t addr, input word_t data, input wrt_type_t wtype,
                                input logic cacop);
        line_t  got;
        index_t idx;
        idx = addr[9:6];
        send_req(addr, data, wtype, 1'b0, cacop, 1'b0);
        wait_event(0, "done of a cached store");
        step();
        check_quiet("after cached store");
        model_mem[idx] = apply_store(model_mem[idx], addr, data, wtype, cacop);
        read_line(idx, got);
        check_val(got, model_mem[idx], "line after cached store");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic reset_test();
        line_t got;
        check_quiet("after reset");
        for (int i = 0; i < SETS; i++) begin
            read_line(i[3:0], got);
            check_val(got, '0, "memory after reset");
        end
    endtask

    task automatic cached_test();
        addr_t addr;
        for (int r = 0; r < 2; r++) begin
            for (int t = 0; t < 3; t++) begin
                for (int off = 0; off < 4; off++) begin
                    addr      = rand_bits(32);
                    addr[1:0] = off[1:0];
                    cached_store(addr, rand_bits(32), type_list[t], 1'b0);
                end
            end
        end
    endtask

    task automatic refill_test();
        addr_t addr;
        word_t data;
        line_t fill;
        line_t got;
        int    delay;
        for (int t = 0; t < 3; t++) begin
            addr = rand_bits(32);
            data = rand_bits(32);
            for (int w = 0; w < LINE_WORDS; w++) begin
                fill[32*w +: 32] = rand_bits(32);
            end
            delay = int'(rand_bits(3)) + 2;
            send_req(addr, data, type_list[t], 1'b0, 1'b0, 1'b1);
            for (int i = 0; i < delay; i++) begin
                check_val(line_t'(busy), line_t'(1'b1), "busy during refill wait");
                check_val(line_t'(done), '0, "done during refill wait");
                step();
            end
            refill_valid = 1'b1;
            refill_data  = fill;
            step();
            refill_valid = 1'b0;
            wait_event(0, "done of a refill store");
            step();
            check_quiet("after refill store");
            model_mem[addr[9:6]] = apply_store(fill, addr, data, type_list[t], 1'b0);
            read_line(addr[9:6], got);
            check_val(got, model_mem[addr[9:6]], "line after refill merge");
        end
    endtask

    task automatic uncached_test();
        addr_t addr;
        word_t data;
        line_t got;
        for (int t = 0; t < 3; t++) begin
            addr = rand_bits(32);
            data = rand_bits(32);
            send_req(addr, data, type_list[t], 1'b1, 1'b0, 1'b0);
            wait_event(1, "uc_wvalid");
            check_val(line_t'(uc_wstrb), line_t'(wstrb_t'(type_list[t] << addr[1:0])),
                      "uc_wstrb");
            check_val(line_t'(uc_wdata), line_t'(lane_copy(data, type_list[t])), "uc_wdata");
            check_val(line_t'(uc_addr), line_t'({addr[31:2], 2'b00}), "uc_addr");
            check_val(line_t'(done), line_t'(1'b1), "done with uc_wvalid");
            step();
            for (int i = 0; i < 4; i++) begin
                check_quiet("after uncached beat");
                step();
            end
            read_line(addr[9:6], got);
            check_val(got, model_mem[addr[9:6]], "line after uncached store");
        end
    endtask

    task automatic cacop_test();
        addr_t addr;
        for (int t = 0; t < 2; t++) begin
            for (int off = 1; off < 4; off++) begin
                addr      = rand_bits(32);
                addr[1:0] = off[1:0];
                cached_store(addr, rand_bits(32), type_list[t], 1'b1);
            end
        end
    endtask

    task automatic ignore_test();
        addr_t addr_a;
        addr_t addr_b;
        word_t data;
        line_t fill;
        line_t got;
        addr_a = rand_bits(32);
        addr_b = rand_bits(32);
        addr_b[9:6] = addr_a[9:6] + 4'd1;      // second request targets another set.
        data = rand_bits(32);
        fill = {LINE_WORDS{rand_bits(32)}};
        send_req(addr_a, data, WRT_WORD, 1'b0, 1'b0, 1'b1);
        req_valid = 1'b1;
        req_addr  = addr_b;
        req_refill = 1'b0;
        step();
        req_valid = 1'b0;
        check_val(line_t'(done), '0, "done after request while busy");
        refill_valid = 1'b1;
        refill_data  = fill;
        step();
        refill_valid = 1'b0;
        wait_event(0, "done of the first request");
        step();
        for (int i = 0; i < 4; i++) begin
            check_quiet("after ignored request");
            step();
        end
        model_mem[addr_a[9:6]] = apply_store(fill, addr_a, data, WRT_WORD, 1'b0);
        // stray refill beat while idle.
        refill_valid = 1'b1;
        refill_data  = ~fill;
        step();
        refill_valid = 1'b0;
        for (int i = 0; i < 4; i++) begin
            check_quiet("after stray refill");
            step();
        end
        read_line(addr_a[9:6], got);
        check_val(got, model_mem[addr_a[9:6]], "line of the accepted request");
        read_line(addr_b[9:6], got);
        check_val(got, model_mem[addr_b[9:6]], "line of the ignored request");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_addr     = '0;
        req_wdata    = '0;
        req_type     = '0;
        req_uncache  = 1'b0;
        req_cacop    = 1'b0;
        req_refill   = 1'b0;
        refill_valid = 1'b0;
        refill_data  = '0;
        rd_index     = '0;
        for (int i = 0; i < SETS; i++) begin
            model_mem[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_test();
        cached_test();
        refill_test();
        uncached_test();
        cacop_test();
        ignore_test();
        if (dcache_wr_path_inst.dcache_store_fsm_inst.dcache_wr_path_sva_inst.fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("sequencer assertions failed during the run");
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
dcache_pkg.sv
dcache_ctrl_pkg.sv
dcache_req_buf.sv
mem_wrt_ctrl_d.sv
dcache_data_mem.sv
dcache_store_fsm.sv
dcache_wr_path.sv
dcache_wr_path_sva.sv
tb_dcache_wr_path.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/1ps --top-module tb_dcache_wr_path -f all.f
	-./obj_dir/Vtb_dcache_wr_path > sim.log 2>&1
	cat sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
